// ==== cp0_pkg.sv ====
package cp0_pkg;

	typedef logic [7:0]  asid_t;
	typedef logic [18:0] vpn2_t; // virtual page pair number
	typedef logic [19:0] pfn_t;
	typedef logic [2:0]  tlb_index_t;

	localparam int TLB_ENTRIES = 8;

	// **************************************************
	// register addresses
	// **************************************************

	localparam cpu_pkg::reg_addr_t CP0_INDEX     = 5'd0;
	localparam cpu_pkg::reg_addr_t CP0_RANDOM    = 5'd1;
	localparam cpu_pkg::reg_addr_t CP0_ENTRY_LO0 = 5'd2;
	localparam cpu_pkg::reg_addr_t CP0_ENTRY_LO1 = 5'd3;
	localparam cpu_pkg::reg_addr_t CP0_CONTEXT   = 5'd4;
	localparam cpu_pkg::reg_addr_t CP0_PAGE_MASK = 5'd5;
	localparam cpu_pkg::reg_addr_t CP0_WIRED     = 5'd6;
	localparam cpu_pkg::reg_addr_t CP0_BAD_VADDR = 5'd8;
	localparam cpu_pkg::reg_addr_t CP0_COUNT     = 5'd9;
	localparam cpu_pkg::reg_addr_t CP0_ENTRY_HI  = 5'd10;
	localparam cpu_pkg::reg_addr_t CP0_COMPARE   = 5'd11;
	localparam cpu_pkg::reg_addr_t CP0_STATUS    = 5'd12;
	localparam cpu_pkg::reg_addr_t CP0_CAUSE     = 5'd13;
	localparam cpu_pkg::reg_addr_t CP0_EPC       = 5'd14;
	localparam cpu_pkg::reg_addr_t CP0_PRID      = 5'd15;
	localparam cpu_pkg::reg_addr_t CP0_CONFIG    = 5'd16;
	localparam cpu_pkg::reg_addr_t CP0_ERROR_EPC = 5'd30;

	localparam cpu_pkg::word_t STATUS_RESET = 32'h1040_0000; // cu0 and bev

	typedef struct packed {
		logic [15:0] hi;       // cu, bev and friends
		logic [7:0]  im;
		logic [2:0]  rsv_7_5;
		logic        um;
		logic        rsv_3;
		logic        erl;
		logic        exl;
		logic        ie;
	} cp0_status_t;

	typedef struct packed {
		logic                bd;
		logic                ti;
		logic [1:0]          ce;
		logic [11:0]         rsv_27_16;
		logic [7:0]          ip;
		logic                rsv_7;
		cpu_pkg::exc_code_t  exc_code;
		logic [1:0]          rsv_1_0;
	} cp0_cause_t;

	// register 0 sits in the low word, so regs[addr*32 +: 32] picks one
	typedef struct packed {
		cpu_pkg::word_t        rsv_31;
		cpu_pkg::word_t        error_epc;
		cpu_pkg::word_t [12:0] rsv_29_17;
		cpu_pkg::word_t        config0;
		cpu_pkg::word_t        prid;
		cpu_pkg::word_t        epc;
		cp0_cause_t            cause;
		cp0_status_t           status;
		cpu_pkg::word_t        compare;
		cpu_pkg::word_t        entry_hi;
		cpu_pkg::word_t        count;
		cpu_pkg::word_t        bad_vaddr;
		cpu_pkg::word_t        rsv_7;
		cpu_pkg::word_t        wired;
		cpu_pkg::word_t        page_mask;
		cpu_pkg::word_t        context_reg;
		cpu_pkg::word_t        entry_lo1;
		cpu_pkg::word_t        entry_lo0;
		cpu_pkg::word_t        random;
		cpu_pkg::word_t        index;
	} cp0_regs_t;

	typedef struct packed {
		vpn2_t      vpn2;
		asid_t      asid;
		logic       g;
		pfn_t       pfn0;
		logic [2:0] c0;
		logic       d0;
		logic       v0;
		pfn_t       pfn1;
		logic [2:0] c1;
		logic       d1;
		logic       v1;
	} tlb_entry_t;

	typedef struct packed {
		logic               we;
		cpu_pkg::reg_addr_t waddr;
		logic [2:0]         sel;
		cpu_pkg::word_t     wdata;
	} cp0_wr_req_t;

	typedef struct packed {
		logic               flush;
		logic               eret;
		logic               delayslot;
		cpu_pkg::exc_code_t code;
		cpu_pkg::word_t     cur_pc;
		cpu_pkg::word_t     extra;   // bad address for address and tlb errors
	} except_req_t;

endpackage

// ==== cp0_regs.sv ====
`timescale 1ns/1ns

module cp0_regs (
	input  logic                 clk,
	input  logic                 rst,

	input  cpu_pkg::reg_addr_t   raddr1,
	input  cpu_pkg::reg_addr_t   raddr2,
	input  logic [2:0]           rsel1,
	input  logic [2:0]           rsel2,

	input  cp0_pkg::cp0_wr_req_t wr,
	input  cpu_pkg::word_t       wmask,
	input  cp0_pkg::except_req_t except_req,
	input  logic [5:0]           int_req,

	input  logic [2:0]           tlb_req, // {r, p, wi}
	cp0_tlb_if.regs              tlbi,

	output cpu_pkg::word_t       rdata1,
	output cpu_pkg::word_t       rdata2,
	output cp0_pkg::cp0_regs_t   regs,
	output cp0_pkg::asid_t       asid,
	output logic                 user_mode
);

	cp0_pkg::cp0_regs_t regs_q, regs_d;

	function automatic cpu_pkg::word_t read_reg(
		input cp0_pkg::cp0_regs_t r,
		input cpu_pkg::reg_addr_t addr,
		input logic [2:0]         sel
	);
		if (sel == 3'd0)
			return r[addr * 32 +: 32];
		return cpu_pkg::ZERO_WORD;
	endfunction

	// forwarded from next state
	assign rdata1 = read_reg(regs_d, raddr1, rsel1);
	assign rdata2 = read_reg(regs_d, raddr2, rsel2);

	assign regs      = regs_q;
	assign asid      = regs_q.entry_hi[7:0];
	assign user_mode = regs_q.status.um & ~regs_q.status.erl & ~regs_q.status.exl;

	assign tlbi.tlbr_req  = tlb_req[2];
	assign tlbi.tlbp_req  = tlb_req[1];
	assign tlbi.tlbwi_req = tlb_req[0];
	assign tlbi.entry_hi  = regs_q.entry_hi;
	assign tlbi.entry_lo0 = regs_q.entry_lo0;
	assign tlbi.entry_lo1 = regs_q.entry_lo1;
	assign tlbi.index     = regs_q.index;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			regs_q        <= '0;
			regs_q.random <= cp0_pkg::TLB_ENTRIES - 1;
			regs_q.status <= cp0_pkg::STATUS_RESET;
		end
		else
			regs_q <= regs_d;
	end

	// **************************************************
	// next state
	// **************************************************

	always_comb
	begin
		regs_d = regs_q;
		regs_d.count = regs_q.count + 32'd1;
		regs_d.cause.ip[7:2] = int_req; // hardware interrupt lines

		if (wr.we)
			regs_d[wr.waddr * 32 +: 32] = (wr.wdata & wmask)
				| (regs_d[wr.waddr * 32 +: 32] & ~wmask);

		if (tlbi.tlbr_req)
		begin
			regs_d.entry_hi[31:13] = tlbi.tlbr_res.vpn2;
			regs_d.entry_hi[7:0]   = tlbi.tlbr_res.asid;
			regs_d.entry_lo0 = {6'b0, tlbi.tlbr_res.pfn0, tlbi.tlbr_res.c0,
				tlbi.tlbr_res.d0, tlbi.tlbr_res.v0, tlbi.tlbr_res.g};
			regs_d.entry_lo1 = {6'b0, tlbi.tlbr_res.pfn1, tlbi.tlbr_res.c1,
				tlbi.tlbr_res.d1, tlbi.tlbr_res.v1, tlbi.tlbr_res.g};
		end

		if (tlbi.tlbp_req)
			regs_d.index = tlbi.tlbp_res;

		if (except_req.flush)
		begin
			if (except_req.eret)
			begin
				if (regs_d.status.erl)
					regs_d.status.erl = 1'b0;
				else
					regs_d.status.exl = 1'b0;
			end
			else
			begin
				// nested exceptions keep the first epc
				if (!regs_d.status.exl)
				begin
					regs_d.cause.bd = except_req.delayslot;
					regs_d.epc = except_req.delayslot ? except_req.cur_pc - 32'd4
						: except_req.cur_pc;
				end
				regs_d.status.exl     = 1'b1;
				regs_d.cause.ce       = 2'd0;
				regs_d.cause.exc_code = except_req.code;

				case (except_req.code)
					cpu_pkg::EXC_ADEL,
					cpu_pkg::EXC_ADES:
						regs_d.bad_vaddr = except_req.extra;
					cpu_pkg::EXC_MOD,
					cpu_pkg::EXC_TLBL,
					cpu_pkg::EXC_TLBS:
					begin
						regs_d.bad_vaddr             = except_req.extra;
						regs_d.context_reg[22:4]     = except_req.extra[31:13]; // badvpn2
						regs_d.entry_hi[31:13]       = except_req.extra[31:13];
					end
					default: ;
				endcase
			end
		end
	end

endmodule

// ==== cp0_sys.f ====
cpu_pkg.sv
cp0_pkg.sv
cp0_tlb_if.sv
cp0_write_mask.sv
cp0_regs.sv
exc_unit.sv
tlb.sv
cp0_sys.sv
cp0_sys_chk.sv
tb_cp0_sys.sv

// ==== cp0_sys.sv ====
`timescale 1ns/1ns

module cp0_sys (
	input  logic               clk,
	input  logic               rst,
	input  cpu_pkg::reg_addr_t raddr1,
	input  logic [2:0]         rsel1,
	output cpu_pkg::word_t     rdata1,
	input  cpu_pkg::reg_addr_t raddr2,
	input  logic [2:0]         rsel2,
	output cpu_pkg::word_t     rdata2,
	input  logic               we,
	input  cpu_pkg::reg_addr_t waddr,
	input  logic [2:0]         wsel,
	input  cpu_pkg::word_t     wdata,
	input  logic [5:0]         int_req,
	input  logic               tlbr,
	input  logic               tlbp,
	input  logic               tlbwi,
	input  logic [6:0]         exc_flags, // {adel_if, ri, ov, sys, bp, adel, ades}
	input  logic               tlb_miss_ld,
	input  logic               tlb_miss_st,
	input  logic               eret,
	input  logic               delayslot,
	input  cpu_pkg::word_t     cur_pc,
	input  cpu_pkg::word_t     bad_addr,
	output logic               flush,
	output cpu_pkg::word_t     exc_pc,
	output logic               user_mode,
	output cp0_pkg::asid_t     asid,
	input  cpu_pkg::word_t     lookup_vaddr,
	output logic               lookup_hit,
	output cpu_pkg::word_t     lookup_paddr
);

	cp0_pkg::cp0_wr_req_t wr;
	cp0_pkg::except_req_t except_req;
	cp0_pkg::cp0_regs_t   regs;
	cpu_pkg::word_t       wmask;

	cp0_tlb_if tlbi ();

	assign wr = '{we: we, waddr: waddr, sel: wsel, wdata: wdata};

	cp0_write_mask i_cp0_write_mask (
		.sel  (wsel),
		.addr (waddr),
		.mask (wmask)
	);

	// **************************************************
	// exception producer, register state, tlb consumer
	// **************************************************

	exc_unit i_exc_unit (
		.exc_flags, .tlb_miss_ld, .tlb_miss_st, .eret, .delayslot,
		.cur_pc, .bad_addr, .regs, .except_req, .flush, .exc_pc
	);

	cp0_regs i_cp0_regs (
		.clk, .rst, .raddr1, .raddr2, .rsel1, .rsel2,
		.wr, .wmask, .except_req, .int_req,
		.tlb_req ({tlbr, tlbp, tlbwi}),
		.tlbi    (tlbi.regs),
		.rdata1, .rdata2, .regs, .asid, .user_mode
	);

	tlb i_tlb (
		.clk, .rst,
		.tlbi         (tlbi.tlb),
		.lookup_vaddr,
		.lookup_asid  (asid),
		.lookup_hit,
		.lookup_paddr
	);

endmodule

// ==== cp0_sys_chk.sv ====
`timescale 1ns/1ns

module cp0_sys_chk (
	input logic           clk,
	input logic           rst,
	input logic           flush,
	input logic           eret,
	input cpu_pkg::word_t exc_pc,
	input logic           tlbr,
	input logic           tlbp,
	input logic           lookup_hit
);

	// **************************************************
	// exception redirect
	// **************************************************

	flush_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(flush))
		else $error("flush is unknown");

	flush_to_vector: assert property (@(posedge clk) disable iff (rst)
		flush && !eret |-> exc_pc == cpu_pkg::EXC_VECTOR)
		else $error("exception redirect is not the general vector");

	// **************************************************
	// tlb side
	// **************************************************

	probe_read_apart: assert property (@(posedge clk) disable iff (rst) !(tlbp && tlbr))
		else $error("tlbp and tlbr strobes high together");

	no_hit_after_reset: assert property (@(posedge clk) $fell(rst) |-> !lookup_hit)
		else $error("lookup hit in the first cycle after reset");

endmodule

// ==== cp0_tlb_if.sv ====
`timescale 1ns/1ns

interface cp0_tlb_if;

	logic                   tlbr_req;
	logic                   tlbp_req;
	logic                   tlbwi_req;
	cpu_pkg::word_t         entry_hi;
	cpu_pkg::word_t         entry_lo0;
	cpu_pkg::word_t         entry_lo1;
	cpu_pkg::word_t         index;
	cp0_pkg::tlb_entry_t    tlbr_res;
	cpu_pkg::word_t         tlbp_res; // bit 31 set on a probe miss

	modport regs (
		output tlbr_req, tlbp_req, tlbwi_req,
		output entry_hi, entry_lo0, entry_lo1, index,
		input  tlbr_res, tlbp_res
	);

	modport tlb (
		input  tlbr_req, tlbp_req, tlbwi_req,
		input  entry_hi, entry_lo0, entry_lo1, index,
		output tlbr_res, tlbp_res
	);

endinterface

// ==== cp0_write_mask.sv ====
`timescale 1ns/1ns

module cp0_write_mask (
	input  logic [2:0]         sel,
	input  cpu_pkg::reg_addr_t addr,
	output cpu_pkg::word_t     mask
);

	always_comb
	begin
		if (sel != 3'd0)
			mask = cpu_pkg::ZERO_WORD;
		else
		begin
			case (addr)
				cp0_pkg::CP0_INDEX:     mask = 32'h0000_0007; // p is set by tlbp only
				cp0_pkg::CP0_ENTRY_LO0: mask = 32'h03ff_ffff;
				cp0_pkg::CP0_ENTRY_LO1: mask = 32'h03ff_ffff;
				cp0_pkg::CP0_CONTEXT:   mask = 32'hff80_0000; // ptebase
				cp0_pkg::CP0_PAGE_MASK: mask = 32'h01ff_e000;
				cp0_pkg::CP0_WIRED:     mask = 32'h0000_0007;
				cp0_pkg::CP0_ENTRY_HI:  mask = 32'hffff_e0ff; // vpn2 and asid
				cp0_pkg::CP0_COMPARE:   mask = 32'hffff_ffff;
				cp0_pkg::CP0_STATUS:    mask = 32'h1040_ff17;
				cp0_pkg::CP0_CAUSE:     mask = 32'h0000_0300; // software ip bits
				cp0_pkg::CP0_EPC:       mask = 32'hffff_ffff;

				// read only
				cp0_pkg::CP0_RANDOM,
				cp0_pkg::CP0_BAD_VADDR,
				cp0_pkg::CP0_COUNT,
				cp0_pkg::CP0_PRID,
				cp0_pkg::CP0_CONFIG,
				cp0_pkg::CP0_ERROR_EPC: mask = cpu_pkg::ZERO_WORD;
				default:                mask = cpu_pkg::ZERO_WORD;
			endcase
		end
	end

endmodule

// ==== cpu_pkg.sv ====
package cpu_pkg;

	// **************************************************
	// core types
	// **************************************************

	typedef logic [31:0] word_t;     // data or address word
	typedef logic [4:0]  reg_addr_t; // register number
	typedef logic [4:0]  exc_code_t; // cause.exccode

	localparam word_t ZERO_WORD = 32'h0000_0000;

	// general exception vector with bev set
	localparam word_t EXC_VECTOR = 32'hbfc0_0380;

	// **************************************************
	// exception codes
	// **************************************************

	localparam exc_code_t EXC_INT  = 5'h00;
	localparam exc_code_t EXC_MOD  = 5'h01;
	localparam exc_code_t EXC_TLBL = 5'h02; // tlb miss on load or fetch
	localparam exc_code_t EXC_TLBS = 5'h03; // tlb miss on store
	localparam exc_code_t EXC_ADEL = 5'h04;
	localparam exc_code_t EXC_ADES = 5'h05;
	localparam exc_code_t EXC_SYS  = 5'h08;
	localparam exc_code_t EXC_BP   = 5'h09;
	localparam exc_code_t EXC_RI   = 5'h0a;
	localparam exc_code_t EXC_OV   = 5'h0c;

endpackage

// ==== exc_unit.sv ====
`timescale 1ns/1ns

module exc_unit (
	input  logic [6:0]           exc_flags, // {adel_if, ri, ov, sys, bp, adel, ades}
	input  logic                 tlb_miss_ld,
	input  logic                 tlb_miss_st,
	input  logic                 eret,
	input  logic                 delayslot,
	input  cpu_pkg::word_t       cur_pc,
	input  cpu_pkg::word_t       bad_addr,
	input  cp0_pkg::cp0_regs_t   regs,
	output cp0_pkg::except_req_t except_req,
	output logic                 flush,
	output cpu_pkg::word_t       exc_pc
);

	logic adel_if, ri, ov, sys, bp, adel, ades;
	logic int_pending;

	assign {adel_if, ri, ov, sys, bp, adel, ades} = exc_flags;

	assign int_pending = regs.status.ie & ~regs.status.exl & ~regs.status.erl
		& (|(regs.cause.ip & regs.status.im));

	// **************************************************
	// priority chain, interrupt first
	// **************************************************

	always_comb
	begin
		except_req.flush     = 1'b1;
		except_req.eret      = 1'b0;
		except_req.delayslot = delayslot;
		except_req.cur_pc    = cur_pc;
		except_req.extra     = bad_addr;
		except_req.code      = cpu_pkg::EXC_INT;

		if (int_pending)
			except_req.code = cpu_pkg::EXC_INT;
		else if (adel_if)
		begin
			except_req.code  = cpu_pkg::EXC_ADEL;
			except_req.extra = cur_pc; // fetch error reports the pc
		end
		else if (ri)          except_req.code = cpu_pkg::EXC_RI;
		else if (ov)          except_req.code = cpu_pkg::EXC_OV;
		else if (sys)         except_req.code = cpu_pkg::EXC_SYS;
		else if (bp)          except_req.code = cpu_pkg::EXC_BP;
		else if (adel)        except_req.code = cpu_pkg::EXC_ADEL;
		else if (ades)        except_req.code = cpu_pkg::EXC_ADES;
		else if (tlb_miss_ld) except_req.code = cpu_pkg::EXC_TLBL;
		else if (tlb_miss_st) except_req.code = cpu_pkg::EXC_TLBS;
		else if (eret)        except_req.eret = 1'b1;
		else                  except_req.flush = 1'b0;
	end

	assign flush  = except_req.flush;
	assign exc_pc = except_req.eret ? (regs.status.erl ? regs.error_epc : regs.epc)
		: cpu_pkg::EXC_VECTOR;

endmodule

// ==== tb_cp0_sys.sv ====
`timescale 1ns/1ns

module tb_cp0_sys;

	logic                 clk;
	logic                 rst;
	cpu_pkg::reg_addr_t   raddr1, raddr2, waddr;
	logic [2:0]           rsel1, rsel2, wsel;
	cpu_pkg::word_t       rdata1, rdata2, wdata;
	logic                 we;
	logic [5:0]           int_req;
	logic                 tlbr, tlbp, tlbwi;
	logic [6:0]           exc_flags; // {adel_if, ri, ov, sys, bp, adel, ades}
	logic                 tlb_miss_ld, tlb_miss_st, eret, delayslot;
	cpu_pkg::word_t       cur_pc, bad_addr, exc_pc;
	logic                 flush, user_mode, lookup_hit;
	cp0_pkg::asid_t       asid;
	cpu_pkg::word_t       lookup_vaddr, lookup_paddr;
	int                   cycle_count = 0;

	cp0_sys i_cp0_sys (.*);

	bind cp0_sys cp0_sys_chk i_cp0_sys_chk (
		.clk(clk), .rst(rst), .flush(flush), .eret(eret), .exc_pc(exc_pc),
		.tlbr(tlbr), .tlbp(tlbp), .lookup_hit(lookup_hit)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// the tests take about 120 cycles
	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == 400)
			stop_with_error("run did not finish within 400 cycles");
	end

	// **************************************************
	// helpers and compare tasks
	// **************************************************

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input string name, input cpu_pkg::word_t got,
		input cpu_pkg::word_t exp);
		if (got !== exp)
			stop_with_error($sformatf("** Error at %0t ns: %s = %h, expected %h",
				$time, name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_with_error($sformatf("** Error at %0t ns: %s = %b, expected %b",
				$time, name, got, exp));
	endtask

	task automatic check_code(input string name, input cpu_pkg::exc_code_t got,
		input cpu_pkg::exc_code_t exp);
		if (got !== exp)
			stop_with_error($sformatf("** Error at %0t ns: %s = %h, expected %h",
				$time, name, got, exp));
	endtask

	task automatic check_asid(input string name, input cp0_pkg::asid_t got,
		input cp0_pkg::asid_t exp);
		if (got !== exp)
			stop_with_error($sformatf("** Error at %0t ns: %s = %h, expected %h",
				$time, name, got, exp));
	endtask

	task automatic clear_strobes();
		we          = 1'b0;
		tlbr        = 1'b0;
		tlbp        = 1'b0;
		tlbwi       = 1'b0;
		exc_flags   = '0;
		tlb_miss_ld = 1'b0;
		tlb_miss_st = 1'b0;
		eret        = 1'b0;
		delayslot   = 1'b0;
	endtask

	// inputs change 1 ns after the edge and outputs are sampled at the falling edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
		clear_strobes();
	endtask

	task automatic cp0_write(input cpu_pkg::reg_addr_t addr, input cpu_pkg::word_t data);
		next_cycle();
		we    = 1'b1;
		waddr = addr;
		wsel  = 3'd0;
		wdata = data;
	endtask

	task automatic cp0_read(input cpu_pkg::reg_addr_t addr, output cpu_pkg::word_t data);
		next_cycle();
		raddr1 = addr;
		rsel1  = 3'd0;
		@(negedge clk);
		data = rdata1;
	endtask

	task automatic wait_flush(input int max_cycles);
		int n;
		n = 0;
		@(negedge clk);
		while (flush !== 1'b1)
		begin
			n++;
			if (n > max_cycles)
				stop_with_error("flush never came for a pending interrupt");
			next_cycle();
			@(negedge clk);
		end
	endtask

	// entry 1 has an invalid odd page and entry 3 is global
	function automatic cp0_pkg::vpn2_t vpn2_of(input int i);
		return 19'h12340 + 19'(i);
	endfunction

	function automatic cp0_pkg::pfn_t pfn_of(input int i, input logic odd);
		return 20'ha0000 + 20'(2 * i) + 20'(odd);
	endfunction

	function automatic cpu_pkg::word_t entry_hi_of(input int i);
		return {vpn2_of(i), 5'b0, 8'h20 + 8'(i)};
	endfunction

	function automatic cpu_pkg::word_t entry_lo_of(input int i, input logic odd);
		logic v;
		logic g;
		v = !(odd && i == 1);
		g = (i == 3);
		return {6'b0, pfn_of(i, odd), 3'd3, 1'b1, v, g}; // pfn, c, d, v, g
	endfunction

	// **************************************************
	// directed tests
	// **************************************************

	task automatic reset_and_masks();
		cpu_pkg::word_t v;
		cp0_read(cp0_pkg::CP0_STATUS, v);
		check_word("status", v, cp0_pkg::STATUS_RESET);
		cp0_read(cp0_pkg::CP0_RANDOM, v);
		check_word("random", v, cp0_pkg::TLB_ENTRIES - 1);
		cp0_write(cp0_pkg::CP0_STATUS, 32'hffff_ffff);
		cp0_write(cp0_pkg::CP0_COMPARE, 32'hffff_ffff);
		cp0_write(cp0_pkg::CP0_PRID, 32'hffff_ffff);
		cp0_read(cp0_pkg::CP0_STATUS, v);
		check_word("status", v, 32'h1040_ff17); // cu0, bev, im, um, erl, exl, ie
		check_bit("user_mode with exl and erl", user_mode, 1'b0);
		cp0_read(cp0_pkg::CP0_COMPARE, v);
		check_word("compare", v, 32'hffff_ffff);
		cp0_read(cp0_pkg::CP0_PRID, v);
		check_word("prid", v, 32'h0000_0000); // read only
		cp0_write(cp0_pkg::CP0_STATUS, cp0_pkg::STATUS_RESET | 32'h0000_0010); // um only
		next_cycle();
		@(negedge clk);
		check_bit("user_mode", user_mode, 1'b1);
		cp0_write(cp0_pkg::CP0_STATUS, cp0_pkg::STATUS_RESET);
		next_cycle();
		raddr1 = cp0_pkg::CP0_STATUS;
		rsel1  = 3'd1;
		@(negedge clk);
		check_word("rdata1 sel 1", rdata1, 32'h0000_0000);
	endtask

	task automatic count_and_forwarding();
		cpu_pkg::word_t c0;
		cpu_pkg::word_t c1;
		cp0_read(cp0_pkg::CP0_COUNT, c0);
		repeat (4) next_cycle();
		cp0_read(cp0_pkg::CP0_COUNT, c1);
		check_word("count delta", c1 - c0, 32'd5);
		cp0_write(cp0_pkg::CP0_ENTRY_HI, 32'habcd_e055);
		raddr1 = cp0_pkg::CP0_ENTRY_HI;
		@(negedge clk);
		check_word("entry_hi same cycle", rdata1, 32'habcd_e055);
	endtask

	task automatic exception_entry_and_eret();
		cpu_pkg::word_t v;
		next_cycle();
		exc_flags = 7'b000_0010; // data adel
		delayslot = 1'b1;
		cur_pc    = 32'h8000_1004;
		bad_addr  = 32'h0000_1235;
		@(negedge clk);
		check_bit("flush", flush, 1'b1);
		check_word("exc_pc", exc_pc, cpu_pkg::EXC_VECTOR);
		next_cycle();
		raddr1 = cp0_pkg::CP0_EPC;
		raddr2 = cp0_pkg::CP0_CAUSE;
		rsel2  = 3'd0;
		@(negedge clk);
		check_word("epc", rdata1, 32'h8000_1000);
		check_bit("cause.bd", rdata2[31], 1'b1);
		check_code("cause.exc_code", rdata2[6:2], cpu_pkg::EXC_ADEL);
		cp0_read(cp0_pkg::CP0_BAD_VADDR, v);
		check_word("bad_vaddr", v, 32'h0000_1235);
		cp0_read(cp0_pkg::CP0_STATUS, v);
		check_bit("status.exl", v[1], 1'b1);

		// a nested exception keeps epc
		next_cycle();
		exc_flags = 7'b010_0000; // ri
		cur_pc    = 32'h8000_2000;
		@(negedge clk);
		check_bit("flush", flush, 1'b1);
		cp0_read(cp0_pkg::CP0_EPC, v);
		check_word("epc", v, 32'h8000_1000);

		next_cycle();
		eret = 1'b1;
		@(negedge clk);
		check_bit("flush", flush, 1'b1);
		check_word("exc_pc", exc_pc, 32'h8000_1000);
		cp0_read(cp0_pkg::CP0_STATUS, v);
		check_bit("status.exl", v[1], 1'b0);
	endtask

	task automatic interrupt_entry();
		cp0_write(cp0_pkg::CP0_STATUS, cp0_pkg::STATUS_RESET | 32'h0000_0401); // im2, ie
		next_cycle();
		int_req = 6'b00_0001;
		wait_flush(8);
		check_word("exc_pc", exc_pc, cpu_pkg::EXC_VECTOR);
		next_cycle();
		raddr2 = cp0_pkg::CP0_CAUSE;
		@(negedge clk);
		check_code("cause.exc_code", rdata2[6:2], cpu_pkg::EXC_INT);
		repeat (3)
		begin
			next_cycle();
			@(negedge clk);
			check_bit("flush with exl set", flush, 1'b0);
		end
		next_cycle();
		int_req = '0;
		cp0_write(cp0_pkg::CP0_STATUS, cp0_pkg::STATUS_RESET);
	endtask

	task automatic probe_check(input cpu_pkg::word_t hi, input cpu_pkg::word_t exp);
		cp0_write(cp0_pkg::CP0_ENTRY_HI, hi);
		next_cycle();
		tlbp   = 1'b1;
		raddr1 = cp0_pkg::CP0_INDEX;
		@(negedge clk);
		check_word("index after tlbp", rdata1, exp);
	endtask

	task automatic tlb_instructions();
		cpu_pkg::word_t v;
		for (int i = 0; i < 4; i++)
		begin
			cp0_write(cp0_pkg::CP0_INDEX, i);
			cp0_write(cp0_pkg::CP0_ENTRY_HI, entry_hi_of(i));
			cp0_write(cp0_pkg::CP0_ENTRY_LO0, entry_lo_of(i, 1'b0));
			cp0_write(cp0_pkg::CP0_ENTRY_LO1, entry_lo_of(i, 1'b1));
			next_cycle();
			tlbwi = 1'b1;
		end
		for (int i = 0; i < 4; i++)
		begin
			cp0_write(cp0_pkg::CP0_INDEX, i);
			next_cycle();
			tlbr   = 1'b1;
			raddr1 = cp0_pkg::CP0_ENTRY_HI;
			raddr2 = cp0_pkg::CP0_ENTRY_LO0;
			@(negedge clk);
			check_word("entry_hi after tlbr", rdata1, entry_hi_of(i));
			check_word("entry_lo0 after tlbr", rdata2, entry_lo_of(i, 1'b0));
			cp0_read(cp0_pkg::CP0_ENTRY_LO1, v);
			check_word("entry_lo1 after tlbr", v, entry_lo_of(i, 1'b1));
		end
		probe_check(entry_hi_of(2), 32'd2);
		probe_check({19'h7ffff, 5'b0, 8'h20}, 32'h8000_0000);
		probe_check({vpn2_of(3), 5'b0, 8'h99}, 32'd3); // global ignores asid
	endtask

	task automatic lookup_check(input cp0_pkg::asid_t a, input cpu_pkg::word_t vaddr,
		input logic hit, input cpu_pkg::word_t paddr);
		cp0_write(cp0_pkg::CP0_ENTRY_HI, {24'h0, a});
		next_cycle();
		lookup_vaddr = vaddr;
		@(negedge clk);
		check_asid("asid", asid, a);
		check_bit("lookup_hit", lookup_hit, hit);
		if (hit)
			check_word("lookup_paddr", lookup_paddr, paddr);
	endtask

	task automatic tlb_lookup();
		lookup_check(8'h20, {vpn2_of(0), 1'b0, 12'habc}, 1'b1, {pfn_of(0, 1'b0), 12'habc});
		lookup_check(8'h20, {vpn2_of(0), 1'b1, 12'h123}, 1'b1, {pfn_of(0, 1'b1), 12'h123});
		lookup_check(8'h21, {vpn2_of(1), 1'b0, 12'h456}, 1'b1, {pfn_of(1, 1'b0), 12'h456});
		lookup_check(8'h21, {vpn2_of(1), 1'b1, 12'h456}, 1'b0, '0); // invalid page
		lookup_check(8'h20, {vpn2_of(1), 1'b0, 12'h456}, 1'b0, '0); // wrong asid
		lookup_check(8'h20, {vpn2_of(3), 1'b0, 12'h789}, 1'b1, {pfn_of(3, 1'b0), 12'h789});
	endtask

	task automatic tlb_store_miss();
		cpu_pkg::word_t v;
		next_cycle();
		tlb_miss_st = 1'b1;
		cur_pc      = 32'h8000_3000;
		bad_addr    = 32'h7654_3abc;
		@(negedge clk);
		check_bit("flush", flush, 1'b1);
		cp0_read(cp0_pkg::CP0_BAD_VADDR, v);
		check_word("bad_vaddr", v, 32'h7654_3abc);
		cp0_read(cp0_pkg::CP0_CONTEXT, v);
		check_word("context", v, {9'b0, bad_addr[31:13], 4'b0});
		cp0_read(cp0_pkg::CP0_ENTRY_HI, v);
		check_word("entry_hi.vpn2", v & 32'hffff_e000, {bad_addr[31:13], 13'b0});
		cp0_read(cp0_pkg::CP0_CAUSE, v);
		check_code("cause.exc_code", v[6:2], cpu_pkg::EXC_TLBS);
	endtask

	// **************************************************
	// main sequence
	// **************************************************

	initial
	begin
		rst          = 1'b1;
		raddr1       = '0;
		raddr2       = '0;
		rsel1        = '0;
		rsel2        = '0;
		waddr        = '0;
		wsel         = '0;
		wdata        = '0;
		int_req      = '0;
		cur_pc       = '0;
		bad_addr     = '0;
		lookup_vaddr = '0;
		clear_strobes();
		repeat (4) @(posedge clk);
		#1 rst = 1'b0;

		reset_and_masks();
		count_and_forwarding();
		exception_entry_and_eret();
		interrupt_entry();
		tlb_instructions();
		tlb_lookup();
		tlb_store_miss();

		next_cycle();
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// ==== tlb.sv ====
`timescale 1ns/1ns

module tlb (
	input  logic              clk,
	input  logic              rst,
	cp0_tlb_if.tlb            tlbi,
	input  cpu_pkg::word_t    lookup_vaddr,
	input  cp0_pkg::asid_t    lookup_asid,
	output logic              lookup_hit,
	output cpu_pkg::word_t    lookup_paddr
);

	cp0_pkg::tlb_entry_t entries [cp0_pkg::TLB_ENTRIES];
	cp0_pkg::tlb_index_t idx;
	cp0_pkg::tlb_index_t probe_idx;
	cp0_pkg::tlb_entry_t look_entry;
	logic                probe_hit;
	logic                look_match;

	assign idx = tlbi.index[2:0];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < cp0_pkg::TLB_ENTRIES; i++)
				entries[i] <= '0; // invalid, not global
		end
		else if (tlbi.tlbwi_req)
		begin
			entries[idx].vpn2 <= tlbi.entry_hi[31:13];
			entries[idx].asid <= tlbi.entry_hi[7:0];
			entries[idx].g    <= tlbi.entry_lo0[0] & tlbi.entry_lo1[0];
			entries[idx].pfn0 <= tlbi.entry_lo0[25:6];
			entries[idx].c0   <= tlbi.entry_lo0[5:3];
			entries[idx].d0   <= tlbi.entry_lo0[2];
			entries[idx].v0   <= tlbi.entry_lo0[1];
			entries[idx].pfn1 <= tlbi.entry_lo1[25:6];
			entries[idx].c1   <= tlbi.entry_lo1[5:3];
			entries[idx].d1   <= tlbi.entry_lo1[2];
			entries[idx].v1   <= tlbi.entry_lo1[1];
		end
	end

	// **************************************************
	// probe and lookup match
	// **************************************************

	always_comb
	begin
		probe_hit  = 1'b0;
		probe_idx  = '0;
		look_match = 1'b0;
		look_entry = '0;
		for (int i = 0; i < cp0_pkg::TLB_ENTRIES; i++)
		begin
			if (entries[i].vpn2 == tlbi.entry_hi[31:13]
				&& (entries[i].g || entries[i].asid == tlbi.entry_hi[7:0]))
			begin
				probe_hit = 1'b1;
				probe_idx = cp0_pkg::tlb_index_t'(i);
			end
			if (entries[i].vpn2 == lookup_vaddr[31:13]
				&& (entries[i].g || entries[i].asid == lookup_asid))
			begin
				look_match = 1'b1;
				look_entry = entries[i];
			end
		end
	end

	// results only while the strobe is up
	assign tlbi.tlbr_res = tlbi.tlbr_req ? entries[idx] : '0;
	assign tlbi.tlbp_res = !tlbi.tlbp_req ? cpu_pkg::ZERO_WORD
		: probe_hit ? {29'b0, probe_idx} : 32'h8000_0000;

	// vaddr bit 12 picks the even or odd page
	assign lookup_hit   = look_match & (lookup_vaddr[12] ? look_entry.v1 : look_entry.v0);
	assign lookup_paddr = {lookup_vaddr[12] ? look_entry.pfn1 : look_entry.pfn0,
		lookup_vaddr[11:0]};

endmodule
